/* Makefile */
# Verilator build and run for the shared-bus core

VERILATOR ?= verilator
TOP       ?= shouse_bus_tb
FLIST     ?= shouse_bus_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Output goes to the terminal and is searched for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "=== PASS ==="

clean:
	rm -rf $(OBJ_DIR)

/* design/shouse_bus_top.sv */
//////////////////////////////////////////////////////////////////////
// Shared-bus core: clock enables, tri-port RAM, key chip, debug view
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module shouse_bus_top
    import shouse_pkg::*;
#(
    parameter int TRI_AW = 11
) (
    input  logic              clk,
    input  logic              reset,
    input  logic [2:0]        busy,
    // Main bus
    input  logic              tri_cs,
    input  logic              key_cs,
    input  logic              brnw,
    input  tri_addr_t         baddr,
    input  byte_t             bdout,
    output byte_t             tri_dout,
    output byte_t             key_dout,
    // MCU
    input  logic              mcu_cs,
    input  logic              mcu_rnw,
    input  logic [TRI_AW-1:0] mcu_addr,
    input  byte_t             mcu_wdata,
    output byte_t             mcu_rdata,
    // Sound CPU
    input  logic              snd_cs,
    input  logic              srnw,
    input  logic [TRI_AW-1:0] snd_addr,
    input  byte_t             snd_wdata,
    output byte_t             snd_rdata,
    // ROM header programming
    input  logic              prog_en,
    input  logic              prog_wr,
    input  prog_addr_t        prog_addr,
    input  byte_t             prog_data,
    input  byte_t             debug_bus,
    output logic              cen_main,
    output logic              cen_snd,
    output logic              cen_mcu,
    output logic [1:0]        io_mode,
    output byte_t             debug_view
);

    slot_e      slot;
    slot_e      last_writer;
    stall_cnt_t stall_cnt;

    shouse_cen_gen u_cen(
        .clk        ( clk       ),
        .reset      ( reset     ),
        .busy       ( busy      ),
        .cen_main   ( cen_main  ),
        .cen_snd    ( cen_snd   ),
        .cen_mcu    ( cen_mcu   ),
        .stall_cnt  ( stall_cnt ),
        .slot       ( slot      )
    );

    shouse_triram #(.TRI_AW(TRI_AW)) u_triram(
        .clk        ( clk       ),
        .reset      ( reset     ),
        .cen_main   ( cen_main  ),
        .cen_snd    ( cen_snd   ),
        .cen_mcu    ( cen_mcu   ),
        .tri_cs     ( tri_cs    ),
        .brnw       ( brnw      ),
        .baddr      ( baddr     ),
        .bdout      ( bdout     ),
        .tri_dout   ( tri_dout  ),
        .mcu_cs     ( mcu_cs    ),
        .mcu_rnw    ( mcu_rnw   ),
        .mcu_addr   ( mcu_addr  ),
        .mcu_wdata  ( mcu_wdata ),
        .mcu_rdata  ( mcu_rdata ),
        .snd_cs     ( snd_cs    ),
        .srnw       ( srnw      ),
        .snd_addr   ( snd_addr  ),
        .snd_wdata  ( snd_wdata ),
        .snd_rdata  ( snd_rdata ),
        .last_writer( last_writer )
    );

    shouse_key u_key(
        .clk        ( clk       ),
        .reset      ( reset     ),
        .cen_main   ( cen_main  ),
        .key_cs     ( key_cs    ),
        .brnw       ( brnw      ),
        .baddr      ( baddr[2:0]),
        .bdout      ( bdout     ),
        .key_dout   ( key_dout  ),
        .prog_en    ( prog_en   ),
        .prog_wr    ( prog_wr   ),
        .prog_addr  ( prog_addr ),
        .prog_data  ( prog_data ),
        .io_mode    ( io_mode   )
    );

    shouse_dbg_mux u_dbg(
        .clk        ( clk       ),
        .debug_bus  ( debug_bus ),
        .reset      ( reset     ),
        .busy       ( busy      ),
        .slot       ( slot      ),
        .last_writer( last_writer ),
        .io_mode    ( io_mode   ),
        .stall_cnt  ( stall_cnt ),
        .debug_view ( debug_view )
    );

endmodule

`default_nettype wire

/* design/shouse_cen_gen.sv */
//////////////////////////////////////////////////////////////////////
// Slot sequencer for the main, sound and MCU clock enables
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module shouse_cen_gen
    import shouse_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic [2:0] busy,
    output logic       cen_main,
    output logic       cen_snd,
    output logic       cen_mcu,
    output stall_cnt_t stall_cnt,
    output slot_e      slot
);

    logic  run;
    logic  stalled;
    slot_e slot_nxt;

    assign stalled = |busy;

    always_comb begin
        case (slot)
            SLOT_MAIN: slot_nxt = SLOT_SND;
            SLOT_SND:  slot_nxt = SLOT_MCU;
            SLOT_MCU:  slot_nxt = SLOT_IDLE;
            default:   slot_nxt = SLOT_MAIN;
        endcase
    end

    // Run rises one clock after reset so the main slot comes first
    always_ff @(posedge clk) begin
        if (reset) begin
            slot      <= SLOT_MAIN;
            run       <= 1'b0;
            stall_cnt <= '0;
        end else begin
            run <= 1'b1;
            if (stalled) begin
                stall_cnt <= stall_cnt + stall_cnt_t'(1);
            end else if (run) begin
                slot <= slot_nxt;
            end
        end
    end

    // No enables while the slot is frozen by busy
    assign cen_main = run && !stalled && (slot == SLOT_MAIN);
    assign cen_snd  = run && !stalled && (slot == SLOT_SND);
    assign cen_mcu  = run && !stalled && (slot == SLOT_MCU);

    a_cen_onehot0: assert property (
        @(posedge clk) disable iff (reset) $onehot0({cen_main, cen_snd, cen_mcu})
    );

endmodule

`default_nettype wire

/* design/shouse_dbg_mux.sv */
//////////////////////////////////////////////////////////////////////
// Debug byte selector driven by debug_bus[7:6]
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module shouse_dbg_mux
    import shouse_pkg::*;
(
    input  logic       clk,
    input  byte_t      debug_bus,
    input  logic       reset,
    input  logic [2:0] busy,
    input  slot_e      slot,
    input  slot_e      last_writer,
    input  logic [1:0] io_mode,
    input  stall_cnt_t stall_cnt,
    output byte_t      debug_view
);

    always_comb begin
        case (debug_bus[7:6])
            DBG_RESET: debug_view = {2'd0, reset, busy, slot};
            DBG_TRI:   debug_view = {6'd0, last_writer};
            DBG_KEY:   debug_view = {6'd0, io_mode};
            // bit 0 picks the byte of the stall count
            DBG_STALL: debug_view = debug_bus[0] ? stall_cnt[7:0] : stall_cnt[15:8];
            default:   debug_view = '0;
        endcase
    end

    // Stall count shown here moves by one per busy clock
    a_stall_step: assert property (
        @(posedge clk) disable iff (reset)
        |busy |=> stall_cnt == $past(stall_cnt) + stall_cnt_t'(1)
    );

endmodule

`default_nettype wire

/* design/shouse_key.sv */
//////////////////////////////////////////////////////////////////////
// Key-chip registers, loaded from the ROM header, with I/O mode
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module shouse_key
    import shouse_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       cen_main,
    input  logic       key_cs,
    input  logic       brnw,
    input  key_addr_t  baddr,
    input  byte_t      bdout,
    output byte_t      key_dout,
    input  logic       prog_en,
    input  logic       prog_wr,
    input  prog_addr_t prog_addr,
    input  byte_t      prog_data,
    output logic [1:0] io_mode
);

    // Registers 6 and 7 are header-only
    localparam int CPU_REGS = 6;
    localparam int NUM_REGS = 8;

    byte_t key_regs [0:NUM_REGS-1];
    logic  cpu_wr;
    logic  cpu_rd;
    logic  hdr_wr;

    assign cpu_wr = cen_main & key_cs & ~brnw;
    assign cpu_rd = cen_main & key_cs & brnw;
    assign hdr_wr = prog_en & prog_wr;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                key_regs[i] <= '0;
            end
            key_dout <= '0;
        end else begin
            // Header load wins over a CPU write in the same clock
            for (int i = 0; i < NUM_REGS; i++) begin
                if (hdr_wr && prog_addr == prog_addr_t'(i)) begin
                    key_regs[i] <= prog_data;
                end else if (cpu_wr && i < CPU_REGS && baddr == key_addr_t'(i)) begin
                    key_regs[i] <= bdout;
                end
            end
            if (cpu_rd) begin
                key_dout <= key_regs[baddr];
            end
        end
    end

    // Cabinet I/O mode from the header byte
    assign io_mode = key_regs[NUM_REGS-1][1:0];

    a_io_mode_hdr_only: assert property (
        @(posedge clk) disable iff (reset) !hdr_wr |=> $stable(io_mode)
    );

endmodule

`default_nettype wire

/* design/shouse_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Shared types and codes for the bus core
//////////////////////////////////////////////////////////////////////
`default_nettype none

package shouse_pkg;

    // One byte on any CPU bus
    typedef logic [7:0] byte_t;

    // Tri-port RAM address, 2 KB
    typedef logic [10:0] tri_addr_t;

    // Key-chip register and header programming addresses
    typedef logic [2:0] key_addr_t;
    typedef logic [2:0] prog_addr_t;

    // Clock cycles lost while a bus is busy
    typedef logic [15:0] stall_cnt_t;

    // Time slots of the shared bus
    typedef enum logic [1:0] {
        SLOT_MAIN = 2'd0,
        SLOT_SND  = 2'd1,
        SLOT_MCU  = 2'd2,
        SLOT_IDLE = 2'd3
    } slot_e;

    // Debug selector codes, taken from debug_bus[7:6]
    localparam logic [1:0] DBG_RESET = 2'd0;
    localparam logic [1:0] DBG_TRI   = 2'd1;
    localparam logic [1:0] DBG_KEY   = 2'd2;
    localparam logic [1:0] DBG_STALL = 2'd3;

endpackage

`default_nettype wire

/* design/shouse_triram.sv */
//////////////////////////////////////////////////////////////////////
// Tri-port RAM, one array served to the main, sound and MCU buses
// by time slot
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module shouse_triram
    import shouse_pkg::*;
#(
    parameter int TRI_AW = 11
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              cen_main,
    input  logic              cen_snd,
    input  logic              cen_mcu,
    // Main bus
    input  logic              tri_cs,
    input  logic              brnw,
    input  tri_addr_t         baddr,
    input  byte_t             bdout,
    output byte_t             tri_dout,
    // MCU
    input  logic              mcu_cs,
    input  logic              mcu_rnw,
    input  logic [TRI_AW-1:0] mcu_addr,
    input  byte_t             mcu_wdata,
    output byte_t             mcu_rdata,
    // Sound CPU
    input  logic              snd_cs,
    input  logic              srnw,
    input  logic [TRI_AW-1:0] snd_addr,
    input  byte_t             snd_wdata,
    output byte_t             snd_rdata,
    output slot_e             last_writer
);

    localparam int DEPTH = 1 << TRI_AW;

    byte_t             mem [0:DEPTH-1];
    logic [TRI_AW-1:0] sel_addr;
    logic              sel_rd;
    logic              sel_we;
    byte_t             sel_wdata;
    slot_e             sel_port;
    byte_t             rd_byte;

    // Port of the current slot drives the array
    always_comb begin
        sel_addr  = '0;
        sel_rd    = 1'b0;
        sel_we    = 1'b0;
        sel_wdata = '0;
        sel_port  = SLOT_IDLE;
        if (cen_main) begin
            sel_addr  = baddr[TRI_AW-1:0];
            sel_rd    = tri_cs & brnw;
            sel_we    = tri_cs & ~brnw;
            sel_wdata = bdout;
            sel_port  = SLOT_MAIN;
        end else if (cen_snd) begin
            sel_addr  = snd_addr;
            sel_rd    = snd_cs & srnw;
            sel_we    = snd_cs & ~srnw;
            sel_wdata = snd_wdata;
            sel_port  = SLOT_SND;
        end else if (cen_mcu) begin
            sel_addr  = mcu_addr;
            sel_rd    = mcu_cs & mcu_rnw;
            sel_we    = mcu_cs & ~mcu_rnw;
            sel_wdata = mcu_wdata;
            sel_port  = SLOT_MCU;
        end
    end

    assign rd_byte = mem[sel_addr];

    always_ff @(posedge clk) begin
        if (sel_we) begin
            mem[sel_addr] <= sel_wdata;
        end
    end

    // Each output holds until its own port reads again
    always_ff @(posedge clk) begin
        if (reset) begin
            tri_dout    <= '0;
            snd_rdata   <= '0;
            mcu_rdata   <= '0;
            last_writer <= SLOT_IDLE;
        end else begin
            if (sel_rd) begin
                case (sel_port)
                    SLOT_MAIN: tri_dout  <= rd_byte;
                    SLOT_SND:  snd_rdata <= rd_byte;
                    SLOT_MCU:  mcu_rdata <= rd_byte;
                    default:   ;
                endcase
            end
            if (sel_we) begin
                last_writer <= sel_port;
            end
        end
    end

    a_write_in_slot: assert property (
        @(posedge clk) disable iff (reset) sel_we |-> $onehot({cen_main, cen_snd, cen_mcu})
    );

endmodule

`default_nettype wire

/* shouse_bus_top.f */
design/shouse_pkg.sv
design/shouse_cen_gen.sv
design/shouse_key.sv
design/shouse_triram.sv
design/shouse_dbg_mux.sv
design/shouse_bus_top.sv
test/shouse_bus_tb.sv

/* test/shouse_bus_tb.sv */
//////////////////////////////////////////////////////////////////////
// Table-driven testbench for the shared-bus core with a RAM model
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module shouse_bus_tb
    import shouse_pkg::*;
;

    localparam int TRI_AW      = 11;
    localparam int NUM_ENTRIES = 24;
    localparam int WAIT_LIMIT  = 20;

    logic              clk;
    logic              reset;
    logic [2:0]        busy;
    logic              tri_cs;
    logic              key_cs;
    logic              brnw;
    tri_addr_t         baddr;
    byte_t             bdout;
    byte_t             tri_dout;
    byte_t             key_dout;
    logic              mcu_cs;
    logic              mcu_rnw;
    logic [TRI_AW-1:0] mcu_addr;
    byte_t             mcu_wdata;
    byte_t             mcu_rdata;
    logic              snd_cs;
    logic              srnw;
    logic [TRI_AW-1:0] snd_addr;
    byte_t             snd_wdata;
    byte_t             snd_rdata;
    logic              prog_en;
    logic              prog_wr;
    prog_addr_t        prog_addr;
    byte_t             prog_data;
    byte_t             debug_bus;
    logic              cen_main;
    logic              cen_snd;
    logic              cen_mcu;
    logic [1:0]        io_mode;
    byte_t             debug_view;

    // Stimulus table with one column per field
    slot_e     tbl_port [0:NUM_ENTRIES-1];
    logic      tbl_rnw  [0:NUM_ENTRIES-1];
    tri_addr_t tbl_addr [0:NUM_ENTRIES-1];
    byte_t     tbl_data [0:NUM_ENTRIES-1];
    byte_t     tbl_dbg  [0:NUM_ENTRIES-1];

    // Reference state
    byte_t      ref_mem [0:(1<<TRI_AW)-1];
    byte_t      held    [0:3];
    byte_t      key_exp [0:7];
    slot_e      last_wr_exp;
    stall_cnt_t stall_exp;
    logic [31:0] lcg_state;

    shouse_bus_top #(.TRI_AW(TRI_AW)) dut(
        .clk        ( clk        ),
        .reset      ( reset      ),
        .busy       ( busy       ),
        .tri_cs     ( tri_cs     ),
        .key_cs     ( key_cs     ),
        .brnw       ( brnw       ),
        .baddr      ( baddr      ),
        .bdout      ( bdout      ),
        .tri_dout   ( tri_dout   ),
        .key_dout   ( key_dout   ),
        .mcu_cs     ( mcu_cs     ),
        .mcu_rnw    ( mcu_rnw    ),
        .mcu_addr   ( mcu_addr   ),
        .mcu_wdata  ( mcu_wdata  ),
        .mcu_rdata  ( mcu_rdata  ),
        .snd_cs     ( snd_cs     ),
        .srnw       ( srnw       ),
        .snd_addr   ( snd_addr   ),
        .snd_wdata  ( snd_wdata  ),
        .snd_rdata  ( snd_rdata  ),
        .prog_en    ( prog_en    ),
        .prog_wr    ( prog_wr    ),
        .prog_addr  ( prog_addr  ),
        .prog_data  ( prog_data  ),
        .debug_bus  ( debug_bus  ),
        .cen_main   ( cen_main   ),
        .cen_snd    ( cen_snd    ),
        .cen_mcu    ( cen_mcu    ),
        .io_mode    ( io_mode    ),
        .debug_view ( debug_view )
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic byte_t cen_bits();
        return {5'd0, cen_main, cen_snd, cen_mcu};
    endfunction

    function automatic logic port_en(input slot_e port);
        case (port)
            SLOT_MAIN: return cen_main;
            SLOT_SND:  return cen_snd;
            SLOT_MCU:  return cen_mcu;
            default:   return 1'b0;
        endcase
    endfunction

    function automatic slot_e port_of(input int k);
        case (k)
            0:       return SLOT_MAIN;
            1:       return SLOT_SND;
            default: return SLOT_MCU;
        endcase
    endfunction

    // Next port in rotation
    function automatic slot_e next_port(input slot_e port);
        case (port)
            SLOT_MAIN: return SLOT_SND;
            SLOT_SND:  return SLOT_MCU;
            default:   return SLOT_MAIN;
        endcase
    endfunction

    // Sequencer position one clock after a served slot
    function automatic slot_e slot_after(input slot_e port);
        case (port)
            SLOT_MAIN: return SLOT_SND;
            SLOT_SND:  return SLOT_MCU;
            default:   return SLOT_IDLE;
        endcase
    endfunction

    task automatic fail_run();
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_byte(input string what, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s expected %h got %h", $time, what, exp, got);
            fail_run();
        end
    endtask

    task automatic check_slot(input string what, input slot_e got, input slot_e exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s expected %s got %s",
                     $time, what, exp.name(), got.name());
            fail_run();
        end
    endtask

    task automatic check_mode(input string what, input logic [1:0] got,
                              input logic [1:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s expected %b got %b", $time, what, exp, got);
            fail_run();
        end
    endtask

    task automatic wait_enable(input slot_e port);
        int cycles;
        cycles = 0;
        while (!port_en(port)) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("timed out waiting for port enable");
                fail_run();
            end
        end
    endtask

    task automatic drive_port(input slot_e port, input logic cs, input logic rnw,
                              input tri_addr_t addr, input byte_t data);
        case (port)
            SLOT_MAIN: begin
                tri_cs = cs;
                brnw   = rnw;
                baddr  = addr;
                bdout  = data;
            end
            SLOT_SND: begin
                snd_cs    = cs;
                srnw      = rnw;
                snd_addr  = addr;
                snd_wdata = data;
            end
            SLOT_MCU: begin
                mcu_cs    = cs;
                mcu_rnw   = rnw;
                mcu_addr  = addr;
                mcu_wdata = data;
            end
            default: ;
        endcase
    endtask

    // Strobe is raised in any slot and held until its enable
    task automatic ram_access(input slot_e port, input logic rnw, input tri_addr_t addr,
                              input byte_t data, input byte_t dbg);
        @(negedge clk);
        debug_bus = dbg;
        drive_port(port, 1'b1, rnw, addr, data);
        wait_enable(port);
        @(negedge clk);
        if (rnw) begin
            held[port] = ref_mem[addr];
        end else begin
            ref_mem[addr] = data;
            last_wr_exp   = port;
        end
        check_byte("main read data", tri_dout, held[SLOT_MAIN]);
        check_byte("sound read data", snd_rdata, held[SLOT_SND]);
        check_byte("mcu read data", mcu_rdata, held[SLOT_MCU]);
        check_byte("debug upper bits", debug_view & 8'hfc, 8'h00);
        if (dbg[7:6] == DBG_TRI) begin
            check_slot("last writer", slot_e'(debug_view[1:0]), last_wr_exp);
        end else begin
            check_slot("slot after service", slot_e'(debug_view[1:0]), slot_after(port));
        end
        drive_port(port, 1'b0, 1'b1, '0, '0);
    endtask

    task automatic build_table();
        slot_e w;
        for (int g = 0; g < NUM_ENTRIES / 3; g++) begin
            lcg_state = lcg_next(lcg_state);
            w = port_of(g % 3);
            for (int j = 0; j < 3; j++) begin
                tbl_addr[3*g+j] = lcg_state[26:16];
                tbl_rnw[3*g+j]  = (j != 0);
                tbl_data[3*g+j] = (j == 0) ? lcg_state[7:0] : 8'h00;
                tbl_dbg[3*g+j]  = (j == 0) ? {DBG_TRI, 6'd0} : {DBG_RESET, 6'd0};
            end
            tbl_port[3*g]   = w;
            tbl_port[3*g+1] = next_port(w);
            tbl_port[3*g+2] = next_port(next_port(w));
        end
    endtask

    // Sound read raised in the main slot and served only in its own slot
    task automatic out_of_slot_read(input tri_addr_t addr);
        byte_t fresh;
        fresh = held[SLOT_SND] ^ 8'h5a;
        ram_access(SLOT_MCU, 1'b0, addr, fresh, 8'h00);
        @(negedge clk);
        wait_enable(SLOT_MAIN);
        drive_port(SLOT_SND, 1'b1, 1'b1, addr, 8'h00);
        @(negedge clk);
        check_byte("enables after main slot", cen_bits(), 8'b010);
        check_byte("sound read before its slot", snd_rdata, held[SLOT_SND]);
        @(negedge clk);
        drive_port(SLOT_SND, 1'b0, 1'b1, '0, '0);
        held[SLOT_SND] = fresh;
        check_byte("sound read in its slot", snd_rdata, held[SLOT_SND]);
    endtask

    task automatic stall_test(input int n);
        @(negedge clk);
        debug_bus = {DBG_STALL, 6'd1};
        @(negedge clk);
        wait_enable(SLOT_SND);
        check_byte("stall low byte before busy", debug_view, stall_exp[7:0]);
        busy = 3'b010;
        for (int i = 1; i <= n; i++) begin
            @(negedge clk);
            check_byte("enables while busy", cen_bits(), 8'h00);
            check_byte("stall low byte", debug_view, 8'(stall_exp + stall_cnt_t'(i)));
        end
        busy      = 3'b000;
        stall_exp = stall_exp + stall_cnt_t'(n);
        debug_bus = {DBG_STALL, 6'd0};
        #1;
        check_byte("resume in frozen slot", cen_bits(), 8'b010);
        @(negedge clk);
        check_byte("next slot after resume", cen_bits(), 8'b001);
        check_byte("stall high byte", debug_view, stall_exp[15:8]);
    endtask

    task automatic key_access(input logic rnw, input key_addr_t addr, input byte_t data);
        @(negedge clk);
        key_cs = 1'b1;
        brnw   = rnw;
        baddr  = {8'd0, addr};
        bdout  = data;
        wait_enable(SLOT_MAIN);
        @(negedge clk);
        key_cs = 1'b0;
        brnw   = 1'b1;
        if (rnw) begin
            check_byte("key register", key_dout, key_exp[addr]);
        end
    endtask

    task automatic key_test();
        byte_t data;
        // Header load of the I/O mode byte and key identifier
        lcg_state = lcg_next(lcg_state);
        @(negedge clk);
        prog_en   = 1'b1;
        prog_wr   = 1'b1;
        prog_addr = 3'd7;
        prog_data = lcg_state[15:8] | 8'h01;
        key_exp[7] = prog_data;
        @(negedge clk);
        prog_addr = 3'd6;
        prog_data = lcg_state[23:16];
        key_exp[6] = prog_data;
        @(negedge clk);
        prog_en = 1'b0;
        prog_wr = 1'b0;
        check_mode("io mode after header", io_mode, key_exp[7][1:0]);
        for (int r = 0; r < 8; r++) begin
            lcg_state = lcg_next(lcg_state);
            data = (r >= 6) ? ~key_exp[r] : lcg_state[7:0];
            key_access(1'b0, key_addr_t'(r), data);
            if (r < 6) begin
                key_exp[r] = data;
            end
        end
        for (int r = 0; r < 8; r++) begin
            key_access(1'b1, key_addr_t'(r), 8'h00);
        end
        check_mode("io mode after cpu writes", io_mode, key_exp[7][1:0]);
        debug_bus = {DBG_KEY, 6'd0};
        @(negedge clk);
        check_mode("debug io mode", debug_view[1:0], key_exp[7][1:0]);
        check_byte("debug io mode byte", debug_view, {6'd0, key_exp[7][1:0]});
    endtask

    initial begin
        reset       = 1'b1;
        busy        = 3'b000;
        tri_cs      = 1'b0;
        key_cs      = 1'b0;
        brnw        = 1'b1;
        baddr       = '0;
        bdout       = '0;
        mcu_cs      = 1'b0;
        mcu_rnw     = 1'b1;
        mcu_addr    = '0;
        mcu_wdata   = '0;
        snd_cs      = 1'b0;
        srnw        = 1'b1;
        snd_addr    = '0;
        snd_wdata   = '0;
        prog_en     = 1'b0;
        prog_wr     = 1'b0;
        prog_addr   = '0;
        prog_data   = '0;
        debug_bus   = '0;
        lcg_state   = 32'hbcc5fb3e;
        stall_exp   = '0;
        last_wr_exp = SLOT_IDLE;
        for (int p = 0; p < 4; p++) begin
            held[p] = 8'h00;
        end
        for (int r = 0; r < 8; r++) begin
            key_exp[r] = 8'h00;
        end

        repeat (8) begin
            @(negedge clk);
            check_byte("enables in reset", cen_bits(), 8'h00);
        end
        reset = 1'b0;

        // Enable order after reset
        wait_enable(SLOT_MAIN);
        check_byte("first enable", cen_bits(), 8'b100);
        @(negedge clk);
        check_byte("second enable", cen_bits(), 8'b010);
        @(negedge clk);
        check_byte("third enable", cen_bits(), 8'b001);
        @(negedge clk);
        check_byte("idle slot", cen_bits(), 8'b000);

        build_table();
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            ram_access(tbl_port[i], tbl_rnw[i], tbl_addr[i], tbl_data[i], tbl_dbg[i]);
        end

        out_of_slot_read(11'h5a3);
        stall_test(5);
        stall_test(9);
        key_test();

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire
